//--- sources.f
source/video_geom_pkg.sv
source/crop_key_pkg.sv
source/crop_key_decoder.sv
source/line_timing.sv
source/frame_timing.sv
source/screen_monitor.sv
source/video_crop_top.sv
verif/video_crop_tb.sv

//--- verif/video_crop_tb.sv
/*
 * Testbench for the video crop top level.
 * Generates progressive frames of fixed geometry, sends key events and
 * presets, and checks the snapshot offsets, the measured geometry, the
 * mode change counter and the display enable.
 */

`timescale 1ns/10ps
`default_nettype none

module video_crop_tb;

	localparam int LINE_LEN  = 120;
	localparam int HS_LEN    = 8;
	localparam int ACT_START = 20;  // first active count of a line
	localparam int ACT_LEN   = 80;
	localparam int FRAME_LEN = 40;
	localparam int ACT_LINES = 30;
	localparam int WAIT_MAX  = 2 * LINE_LEN * FRAME_LEN + 100;

	logic                    clk_sys;
	logic                    reset;
	logic [7:0]              kbd_data;
	logic [1:0]              kbd_type;
	logic                    kbd_level;
	logic                    preset_load;
	video_geom_pkg::coord_t  preset_hbl_l;
	video_geom_pkg::coord_t  preset_hbl_r;
	video_geom_pkg::coord_t  preset_vbl_t;
	video_geom_pkg::coord_t  preset_vbl_b;
	logic                    hs;
	logic                    vs;
	logic                    hblank;
	logic                    vblank_in;
	logic                    field1;
	logic                    lace;
	video_geom_pkg::res_t    res;
	logic                    de;
	video_geom_pkg::coord_t  scr_hbl_l;
	video_geom_pkg::coord_t  scr_hbl_r;
	video_geom_pkg::coord_t  scr_vbl_t;
	video_geom_pkg::coord_t  scr_vbl_b;
	video_geom_pkg::coord_t  scr_hsize;
	video_geom_pkg::coord_t  scr_vsize;
	video_geom_pkg::res_t    scr_res;
	logic [6:0]              scr_flg;

	int   frame_no;   // bumped at line 0 of every generated frame
	int   gen_line;
	logic vbl_zone;   // line deep inside vertical blanking
	logic de_chk;
	logic de_seen;

	video_geom_pkg::coord_t m_off [4];  // hbl_l, hbl_r, vbl_t, vbl_b
	logic m_alt;

	integer seed;
	int     err_cnt;
	int     test_err;
	int     tests_run;
	int     tests_failed;

	video_crop_top uut (
		.clk_sys, .reset,
		.kbd_data, .kbd_type, .kbd_level,
		.preset_load, .preset_hbl_l, .preset_hbl_r, .preset_vbl_t, .preset_vbl_b,
		.hs, .vs, .hblank, .vblank_in, .field1, .lace, .res,
		.de,
		.scr_hbl_l, .scr_hbl_r, .scr_vbl_t, .scr_vbl_b,
		.scr_hsize, .scr_vsize, .scr_res, .scr_flg
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// de stays low on blank lines once sync has settled
	assert property (@(posedge clk_sys) disable iff (reset) !(de_chk && vbl_zone && de))
		else begin
			$display("Error at %0t: de = 1, expected 0 on blank line %0d", $time, gen_line);
			err_cnt++;
		end

	task automatic check_equal(input string name, input int unsigned got,
			input int unsigned exp);
		assert (got == exp)
			else begin
				$display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
				err_cnt++;
			end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_cnt != test_err)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, (err_cnt == test_err) ? "ok" : "failed");
		test_err = err_cnt;
	endtask

	task automatic run_line(input int line);
		for (int c = 0; c < LINE_LEN; c++) begin
			@(posedge clk_sys);
			#1;
			if (line == 0 && c == 0) begin
				if (de_chk)
					assert (de_seen) else begin
						$display("de never went high in frame %0d", frame_no);
						err_cnt++;
					end
				de_seen  = 1'b0;
				frame_no = frame_no + 1;
			end
			if (de)
				de_seen = 1'b1;
			gen_line  = line;
			hs        = (c >= HS_LEN);
			hblank    = (c < ACT_START) || (c >= ACT_START + ACT_LEN);
			vblank_in = (line >= ACT_LINES);
			vs        = !(line >= FRAME_LEN - 4 && line < FRAME_LEN - 1);  // lines 36 to 38
			vbl_zone  = (line >= ACT_LINES + 2);
		end
	endtask

	task automatic run_video();
		forever begin
			for (int line = 0; line < FRAME_LEN; line++)
				run_line(line);
		end
	endtask

	// returns once the snapshot of the next frame is visible
	task automatic wait_snapshot();
		int start;
		int n;
		@(negedge clk_sys);
		start = frame_no;
		n = 0;
		while (frame_no == start && n < WAIT_MAX) begin
			@(negedge clk_sys);
			n++;
		end
		if (frame_no == start) begin
			$display("timeout while waiting for the next frame");
			err_cnt++;
		end else begin
			repeat (2) @(negedge clk_sys);  // snapshot one edge after frame start
		end
	endtask

	task automatic send_key(input logic [7:0] code, input logic [1:0] typ);
		@(posedge clk_sys);
		#1;
		kbd_data  = code;
		kbd_type  = typ;
		kbd_level = ~kbd_level;  // toggle marks the event
		repeat (2) @(posedge clk_sys);
	endtask

	// offset model from the key rules
	function automatic void model_key(input logic [7:0] code);
		video_geom_pkg::coord_t h_step;
		video_geom_pkg::coord_t v_step;
		h_step = crop_key_pkg::H_STEP_DEF;
		v_step = crop_key_pkg::V_STEP_DEF;
		case (code)
			crop_key_pkg::KEY_UP:    m_off[m_alt ? 3 : 2] += v_step;
			crop_key_pkg::KEY_DOWN:  m_off[m_alt ? 3 : 2] -= v_step;
			crop_key_pkg::KEY_LEFT:  m_off[m_alt ? 1 : 0] += h_step;
			crop_key_pkg::KEY_RIGHT: m_off[m_alt ? 1 : 0] -= h_step;
			crop_key_pkg::KEY_BACKSPACE: begin
				for (int i = 0; i < 4; i++)
					m_off[i] = '0;
			end
			crop_key_pkg::KEY_ALT_L, crop_key_pkg::KEY_ALT_R:       m_alt = 1'b1;
			crop_key_pkg::KEY_ALT_L_UP, crop_key_pkg::KEY_ALT_R_UP: m_alt = 1'b0;
			default: ;
		endcase
	endfunction

	function automatic logic [7:0] pick_key(input int idx);
		case (idx)
			0: return crop_key_pkg::KEY_UP;
			1: return crop_key_pkg::KEY_DOWN;
			2: return crop_key_pkg::KEY_LEFT;
			3: return crop_key_pkg::KEY_RIGHT;
			4: return crop_key_pkg::KEY_ALT_L;
			5: return crop_key_pkg::KEY_ALT_R;
			6: return crop_key_pkg::KEY_ALT_L_UP;
			default: return crop_key_pkg::KEY_ALT_R_UP;
		endcase
	endfunction

	task automatic check_offsets();
		check_equal("scr_hbl_l", scr_hbl_l, m_off[0]);
		check_equal("scr_hbl_r", scr_hbl_r, m_off[1]);
		check_equal("scr_vbl_t", scr_vbl_t, m_off[2]);
		check_equal("scr_vbl_b", scr_vbl_b, m_off[3]);
	endtask

	initial begin
		int         idx;
		logic [6:0] flg0;
		logic [6:0] exp_flg;
		seed = 32'h9f61_27a3;
		{err_cnt, test_err, tests_run, tests_failed, frame_no, gen_line} = '0;
		reset = 1'b1;
		kbd_data = '0;
		kbd_type = '0;
		kbd_level = 1'b0;
		preset_load = 1'b0;
		preset_hbl_l = '0;
		preset_hbl_r = '0;
		preset_vbl_t = '0;
		preset_vbl_b = '0;
		hs = 1'b1;
		vs = 1'b1;
		hblank = 1'b1;
		vblank_in = 1'b0;
		field1 = 1'b0;
		lace = 1'b0;
		res = '0;
		vbl_zone = 1'b0;
		de_chk = 1'b0;
		de_seen = 1'b0;
		m_alt = 1'b0;
		for (int i = 0; i < 4; i++)
			m_off[i] = '0;
		repeat (16) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		@(negedge clk_sys);
		check_equal("de", de, 0);
		check_offsets();
		check_equal("scr_hsize", scr_hsize, 0);
		check_equal("scr_vsize", scr_vsize, 0);
		check_equal("scr_res", scr_res, 0);
		check_equal("scr_flg", scr_flg, 0);
		end_test("reset state");

		fork
			run_video();
		join_none

		repeat (2) wait_snapshot();  // first frame has no vblank edge
		check_equal("scr_hsize", scr_hsize, ACT_LEN);
		check_equal("scr_vsize", scr_vsize, ACT_LINES);
		end_test("geometry");

		for (int i = 0; i < 24; i++) begin
			idx = $unsigned($random(seed)) % 8;
			send_key(pick_key(idx), crop_key_pkg::KEY_EVT_TYPE);
			model_key(pick_key(idx));
			if (i % 6 == 5)
				send_key(crop_key_pkg::KEY_LEFT, 2'd1);  // wrong event type
		end
		send_key(8'h20, crop_key_pkg::KEY_EVT_TYPE);  // unused key code
		wait_snapshot();
		check_offsets();
		end_test("key offsets");

		send_key(crop_key_pkg::KEY_BACKSPACE, crop_key_pkg::KEY_EVT_TYPE);
		model_key(crop_key_pkg::KEY_BACKSPACE);
		wait_snapshot();
		check_offsets();
		@(posedge clk_sys);
		#1;
		preset_hbl_l = 12'd24;
		preset_hbl_r = 12'd12;
		preset_vbl_t = 12'd3;
		preset_vbl_b = 12'hffe;  // counted from frame end
		preset_load  = 1'b1;
		kbd_data     = crop_key_pkg::KEY_LEFT;  // same edge as the preset
		kbd_type     = crop_key_pkg::KEY_EVT_TYPE;
		kbd_level    = ~kbd_level;
		@(posedge clk_sys);
		#1;
		preset_load = 1'b0;
		m_off[0] = preset_hbl_l;
		m_off[1] = preset_hbl_r;
		m_off[2] = preset_vbl_t;
		m_off[3] = preset_vbl_b;
		wait_snapshot();
		check_offsets();
		send_key(crop_key_pkg::KEY_BACKSPACE, crop_key_pkg::KEY_EVT_TYPE);
		model_key(crop_key_pkg::KEY_BACKSPACE);
		end_test("clear and preset");

		wait_snapshot();
		flg0 = scr_flg;
		wait_snapshot();
		check_equal("scr_flg", scr_flg, flg0);
		@(posedge clk_sys);
		#1;
		res = 2'd1;  // hires
		exp_flg = flg0 + 7'd1;
		wait_snapshot();
		check_equal("scr_flg", scr_flg, exp_flg);
		check_equal("scr_res", scr_res, 1);
		wait_snapshot();
		check_equal("scr_flg", scr_flg, exp_flg);
		end_test("mode counter");

		repeat (2) wait_snapshot();  // crop window settles with zero offsets
		de_chk = 1'b1;
		repeat (3) wait_snapshot();
		de_chk = 1'b0;
		end_test("display enable");

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/video_crop_top.sv
/*
 * Video crop top level.
 * Key decoder, line and frame timing and the screen monitor, all on
 * clk_sys. Produces the cropped display enable and the per-frame
 * screen geometry snapshot.
 */

`timescale 1ns/10ps
`default_nettype none

module video_crop_top (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire [7:0]               kbd_data,
	input  wire [1:0]               kbd_type,
	input  wire                     kbd_level,
	input  wire                     preset_load,
	input  video_geom_pkg::coord_t  preset_hbl_l,
	input  video_geom_pkg::coord_t  preset_hbl_r,
	input  video_geom_pkg::coord_t  preset_vbl_t,
	input  video_geom_pkg::coord_t  preset_vbl_b,
	input  wire                     hs,         // active low
	input  wire                     vs,         // active low
	input  wire                     hblank,
	input  wire                     vblank_in,
	input  wire                     field1,
	input  wire                     lace,
	input  video_geom_pkg::res_t    res,
	output wire                     de,
	output video_geom_pkg::coord_t  scr_hbl_l,
	output video_geom_pkg::coord_t  scr_hbl_r,
	output video_geom_pkg::coord_t  scr_vbl_t,
	output video_geom_pkg::coord_t  scr_vbl_b,
	output video_geom_pkg::coord_t  scr_hsize,
	output video_geom_pkg::coord_t  scr_vsize,
	output video_geom_pkg::res_t    scr_res,
	output wire [6:0]               scr_flg
);

	wire vblank = vblank_in | ~vs;  // vsync counts as blanking
	wire hbl;

	video_geom_pkg::coord_t hbl_l;
	video_geom_pkg::coord_t hbl_r;
	video_geom_pkg::coord_t vbl_t;
	video_geom_pkg::coord_t vbl_b;
	video_geom_pkg::coord_t hsize;
	video_geom_pkg::coord_t vsize;
	video_geom_pkg::coord_t vcnt;

	crop_key_decoder #(
		.H_STEP (crop_key_pkg::H_STEP_DEF),
		.V_STEP (crop_key_pkg::V_STEP_DEF)
	) u_keys (
		.clk_sys, .reset,
		.kbd_data, .kbd_type, .kbd_level,
		.preset_load, .preset_hbl_l, .preset_hbl_r, .preset_vbl_t, .preset_vbl_b,
		.hbl_l, .hbl_r, .vbl_t, .vbl_b
	);

	line_timing #(
		.HBL_MARGIN (video_geom_pkg::HBL_MARGIN_DEF)
	) u_line (
		.clk_sys, .reset,
		.hs, .hblank, .field1, .vcnt,
		.hbl_l, .hbl_r,
		.hbl, .hsize
	);

	frame_timing u_frame (
		.clk_sys, .reset,
		.hs, .vs, .vblank, .field1, .lace, .hbl,
		.vbl_t, .vbl_b,
		.vcnt, .vsize, .de
	);

	screen_monitor u_mon (
		.clk_sys, .reset, .vblank,
		.hbl_l, .hbl_r, .vbl_t, .vbl_b,
		.hsize, .vsize, .res,
		.scr_hbl_l, .scr_hbl_r, .scr_vbl_t, .scr_vbl_b,
		.scr_hsize, .scr_vsize, .scr_res, .scr_flg
	);

endmodule

`default_nettype wire

//--- source/screen_monitor.sv
/*
 * Screen monitor.
 * Takes a snapshot of the crop offsets, the measured geometry and the
 * resolution when vblank ends, and counts screen mode changes.
 */

`timescale 1ns/10ps
`default_nettype none

module screen_monitor (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     vblank,
	input  video_geom_pkg::coord_t  hbl_l,
	input  video_geom_pkg::coord_t  hbl_r,
	input  video_geom_pkg::coord_t  vbl_t,
	input  video_geom_pkg::coord_t  vbl_b,
	input  video_geom_pkg::coord_t  hsize,
	input  video_geom_pkg::coord_t  vsize,
	input  video_geom_pkg::res_t    res,
	output video_geom_pkg::coord_t  scr_hbl_l,
	output video_geom_pkg::coord_t  scr_hbl_r,
	output video_geom_pkg::coord_t  scr_vbl_t,
	output video_geom_pkg::coord_t  scr_vbl_b,
	output video_geom_pkg::coord_t  scr_hsize,
	output video_geom_pkg::coord_t  scr_vsize,
	output video_geom_pkg::res_t    scr_res,
	output logic [6:0]              scr_flg
);

	logic vblank_d;
	logic mode_chg;

	assign mode_chg = (scr_res != res) || (scr_hsize != hsize) || (scr_vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vblank_d  <= 1'b0;
			scr_hbl_l <= '0;
			scr_hbl_r <= '0;
			scr_vbl_t <= '0;
			scr_vbl_b <= '0;
			scr_hsize <= '0;
			scr_vsize <= '0;
			scr_res   <= '0;
			scr_flg   <= '0;
		end else begin
			vblank_d <= vblank;
			if (vblank_d && !vblank) begin  // once per frame
				scr_hbl_l <= hbl_l;
				scr_hbl_r <= hbl_r;
				scr_vbl_t <= vbl_t;
				scr_vbl_b <= vbl_b;
				scr_hsize <= hsize;
				scr_vsize <= vsize;
				scr_res   <= res;
				if (mode_chg) scr_flg <= scr_flg + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/frame_timing.sv
/*
 * Frame timing.
 * Counts lines, records end of vblank, end of vsync and frame length,
 * adds the odd field height in interlace, and forms the vertical crop
 * and forced blanks. The display enable is registered from both blanks.
 */

`timescale 1ns/10ps
`default_nettype none

module frame_timing (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     hs,       // active low
	input  wire                     vs,       // active low
	input  wire                     vblank,
	input  wire                     field1,
	input  wire                     lace,
	input  wire                     hbl,
	input  video_geom_pkg::coord_t  vbl_t,
	input  video_geom_pkg::coord_t  vbl_b,
	output video_geom_pkg::coord_t  vcnt,
	output video_geom_pkg::coord_t  vsize,
	output logic                    de
);

	logic hs_d;
	logic vs_d;
	logic vblank_d;
	logic hbl_d;
	logic svbl;  // crop blank
	logic fvbl;  // forced blank
	logic vbl_rise;
	logic vbl_fall;
	logic line_start;

	video_geom_pkg::coord_t vend;      // first active line
	video_geom_pkg::coord_t vmax;      // frame length
	video_geom_pkg::coord_t vs_end;    // line of vsync end
	video_geom_pkg::coord_t f1_vend;
	video_geom_pkg::coord_t f1_vsize;  // odd field height
	video_geom_pkg::coord_t bot_line;

	assign vbl_rise = !vblank_d && vblank;
	assign vbl_fall = vblank_d && !vblank;

	// blanks switch at the start of visible line or at line 0
	assign line_start = (hbl_d && !hbl) || (vcnt == '0);

	// top bit set means counted back from frame end
	assign bot_line = vbl_b[video_geom_pkg::CNT_W-1] ? vmax + vbl_b : vbl_b;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_d     <= 1'b1;
			vs_d     <= 1'b1;
			vblank_d <= 1'b0;
			hbl_d    <= 1'b1;
			vcnt     <= '0;
			vend     <= '0;
			vmax     <= '0;
			vs_end   <= '0;
			f1_vend  <= '0;
			f1_vsize <= '0;
			vsize    <= '0;
			svbl     <= 1'b1;
			fvbl     <= 1'b1;
			de       <= 1'b0;
		end else begin
			hs_d     <= hs;
			vs_d     <= vs;
			vblank_d <= vblank;
			hbl_d    <= hbl;

			if (hs_d && !hs) vcnt <= vcnt + 1'b1;
			if (vbl_rise)    vcnt <= '0;

			if (!lace || !field1) begin
				if (vbl_fall)     vend   <= vcnt;
				if (!vs_d && vs)  vs_end <= vcnt;
				if (vbl_rise) begin
					vmax     <= vcnt;
					vsize    <= vcnt - vend + f1_vsize;  // both fields in lace
					f1_vsize <= '0;
				end
			end else begin
				if (vbl_fall) f1_vend  <= vcnt;
				if (vbl_rise) f1_vsize <= vcnt - f1_vend;
			end

			if (line_start) begin
				if (vcnt == vend + vbl_t) svbl <= 1'b0;
				if (vcnt == bot_line)     svbl <= 1'b1;

				if (vcnt == vmax - video_geom_pkg::VBL_BOT_MARGIN)   fvbl <= 1'b1;
				if (vcnt == vs_end + video_geom_pkg::VBL_TOP_MARGIN) fvbl <= 1'b0;
			end

			de <= !hbl && !svbl && !fvbl;
		end
	end

endmodule

`default_nettype wire

//--- source/line_timing.sv
/*
 * Line timing.
 * Counts pixels from the end of hsync, measures where active video
 * starts and ends, and builds the horizontal blank from the crop
 * offsets plus forced margins at both line ends.
 */

`timescale 1ns/10ps
`default_nettype none

module line_timing #(
	parameter video_geom_pkg::coord_t HBL_MARGIN = video_geom_pkg::HBL_MARGIN_DEF
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     hs,       // active low
	input  wire                     hblank,
	input  wire                     field1,
	input  video_geom_pkg::coord_t  vcnt,
	input  video_geom_pkg::coord_t  hbl_l,
	input  video_geom_pkg::coord_t  hbl_r,
	output wire                     hbl,
	output video_geom_pkg::coord_t  hsize
);

	// compare two counts early to line up with the blank register
	localparam video_geom_pkg::coord_t EDGE_ADJ = 12'd2;

	logic hs_d;
	logic hblank_d;
	logic shbl;  // crop blank
	logic fhbl;  // forced margin blank

	video_geom_pkg::coord_t hcnt;
	video_geom_pkg::coord_t hend;  // active start
	video_geom_pkg::coord_t hsta;  // active end
	video_geom_pkg::coord_t hmax;  // line length
	video_geom_pkg::coord_t crop_on;
	video_geom_pkg::coord_t crop_off;

	assign crop_off = hend + hbl_l - EDGE_ADJ;
	assign crop_on  = hsta + hbl_r - EDGE_ADJ;

	assign hbl = fhbl | shbl | ~hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_d     <= 1'b1;
			hblank_d <= 1'b0;
			hcnt     <= '0;
			hend     <= '0;
			hsta     <= '0;
			hmax     <= '0;
			shbl     <= 1'b1;
			fhbl     <= 1'b1;
			hsize    <= '0;
		end else begin
			hs_d     <= hs;
			hblank_d <= hblank;

			hcnt <= hcnt + 1'b1;
			if (!hs) hcnt <= '0;  // held at zero through sync

			if (hblank_d && !hblank) hend <= hcnt;
			if (!hblank_d && hblank) hsta <= hcnt;
			if (hs_d && !hs)         hmax <= hcnt;

			if (hcnt == crop_off) shbl <= 1'b0;
			if (hcnt == crop_on)  shbl <= 1'b1;

			if (hcnt == HBL_MARGIN)        fhbl <= 1'b0;
			if (hcnt == hmax - HBL_MARGIN) fhbl <= 1'b1;

			// width taken from line 1 of an even field
			if (!hblank_d && hblank && !field1 && (vcnt == 12'd1)) hsize <= hcnt - hend;
		end
	end

endmodule

`default_nettype wire

//--- source/crop_key_decoder.sv
/*
 * Crop key decoder.
 * Watches the toggling keyboard event level and turns arrow keys
 * into four crop offsets. Alt selects the right / bottom offset,
 * backspace clears all of them and a preset strobe overrides.
 */

`timescale 1ns/10ps
`default_nettype none

module crop_key_decoder #(
	parameter int H_STEP = crop_key_pkg::H_STEP_DEF,
	parameter int V_STEP = crop_key_pkg::V_STEP_DEF
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire [7:0]               kbd_data,
	input  wire [1:0]               kbd_type,
	input  wire                     kbd_level,
	input  wire                     preset_load,
	input  video_geom_pkg::coord_t  preset_hbl_l,
	input  video_geom_pkg::coord_t  preset_hbl_r,
	input  video_geom_pkg::coord_t  preset_vbl_t,
	input  video_geom_pkg::coord_t  preset_vbl_b,
	output video_geom_pkg::coord_t  hbl_l,
	output video_geom_pkg::coord_t  hbl_r,
	output video_geom_pkg::coord_t  vbl_t,
	output video_geom_pkg::coord_t  vbl_b
);

	localparam video_geom_pkg::coord_t H_INC = video_geom_pkg::coord_t'(H_STEP);
	localparam video_geom_pkg::coord_t V_INC = video_geom_pkg::coord_t'(V_STEP);

	logic level_d;  // level seen on previous clock
	logic alt;      // alt key held
	logic key_evt;

	// new event whenever the level toggles
	assign key_evt = (level_d ^ kbd_level) && (kbd_type == crop_key_pkg::KEY_EVT_TYPE);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_d <= 1'b0;
			alt     <= 1'b0;
			hbl_l   <= '0;
			hbl_r   <= '0;
			vbl_t   <= '0;
			vbl_b   <= '0;
		end else begin
			level_d <= kbd_level;

			if (key_evt) begin
				case (kbd_data)
					crop_key_pkg::KEY_BACKSPACE: begin
						hbl_l <= '0;
						hbl_r <= '0;
						vbl_t <= '0;
						vbl_b <= '0;
					end
					crop_key_pkg::KEY_UP: begin
						if (alt) vbl_b <= vbl_b + V_INC;
						else     vbl_t <= vbl_t + V_INC;
					end
					crop_key_pkg::KEY_DOWN: begin
						if (alt) vbl_b <= vbl_b - V_INC;
						else     vbl_t <= vbl_t - V_INC;
					end
					crop_key_pkg::KEY_LEFT: begin
						if (alt) hbl_r <= hbl_r + H_INC;
						else     hbl_l <= hbl_l + H_INC;
					end
					crop_key_pkg::KEY_RIGHT: begin
						if (alt) hbl_r <= hbl_r - H_INC;
						else     hbl_l <= hbl_l - H_INC;
					end
					crop_key_pkg::KEY_ALT_L, crop_key_pkg::KEY_ALT_R:       alt <= 1'b1;
					crop_key_pkg::KEY_ALT_L_UP, crop_key_pkg::KEY_ALT_R_UP: alt <= 1'b0;
					default: ;  // other keys ignored
				endcase
			end

			// preset wins over a key on the same edge
			if (preset_load) begin
				hbl_l <= preset_hbl_l;
				hbl_r <= preset_hbl_r;
				vbl_t <= preset_vbl_t;
				vbl_b <= preset_vbl_b;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/crop_key_pkg.sv
/*
 * Crop key definitions.
 * Keyboard event type, the key codes that move the crop window
 * and the default crop step sizes.
 */

`default_nettype none

package crop_key_pkg;

	localparam logic [1:0] KEY_EVT_TYPE = 2'd3;  // event carries a key code

	// key codes as delivered by the host
	localparam logic [7:0] KEY_BACKSPACE = 8'h41;
	localparam logic [7:0] KEY_UP        = 8'h4C;
	localparam logic [7:0] KEY_DOWN      = 8'h4D;
	localparam logic [7:0] KEY_RIGHT     = 8'h4E;
	localparam logic [7:0] KEY_LEFT      = 8'h4F;
	localparam logic [7:0] KEY_ALT_L     = 8'h64;
	localparam logic [7:0] KEY_ALT_R     = 8'h65;
	localparam logic [7:0] KEY_ALT_L_UP  = 8'hE4;  // release codes
	localparam logic [7:0] KEY_ALT_R_UP  = 8'hE5;

	// crop steps per key press
	localparam int H_STEP_DEF = 4;  // pixels
	localparam int V_STEP_DEF = 1;  // lines

endpackage

`default_nettype wire

//--- source/video_geom_pkg.sv
/*
 * Video geometry definitions.
 * Shared counter width, coordinate and resolution types, and the
 * forced blanking margins used by the line and frame timing blocks.
 */

`default_nettype none

package video_geom_pkg;

	// width of every pixel / line counter and offset
	localparam int CNT_W = 12;

	// unsigned pixel or line coordinate
	typedef logic [CNT_W-1:0] coord_t;

	// bit 0 hires, bit 1 superhires
	typedef logic [1:0] res_t;

	// forced horizontal blank, counts from each end of the line
	localparam coord_t HBL_MARGIN_DEF = 12'd8;

	// forced vertical blank around the sync area, in lines
	localparam coord_t VBL_TOP_MARGIN = 12'd2;  // after end of vsync
	localparam coord_t VBL_BOT_MARGIN = 12'd1;  // before frame end

endpackage

`default_nettype wire
